// ==== common/mips_pkg.sv ====
package mips_pkg;

    localparam int data_width = 32;
    localparam int reg_count  = 32;
    localparam int addr_width = $clog2(reg_count);

    // primary opcodes
    localparam logic [5:0] op_rtype = 6'b000000;
    localparam logic [5:0] op_j     = 6'b000010;
    localparam logic [5:0] op_jal   = 6'b000011;
    localparam logic [5:0] op_beq   = 6'b000100;
    localparam logic [5:0] op_bne   = 6'b000101;
    localparam logic [5:0] op_blez  = 6'b000110;
    localparam logic [5:0] op_bgtz  = 6'b000111;
    localparam logic [5:0] op_addi  = 6'b001000;
    localparam logic [5:0] op_addiu = 6'b001001;
    localparam logic [5:0] op_slti  = 6'b001010;
    localparam logic [5:0] op_sltiu = 6'b001011;
    localparam logic [5:0] op_andi  = 6'b001100;
    localparam logic [5:0] op_ori   = 6'b001101;
    localparam logic [5:0] op_xori  = 6'b001110;
    localparam logic [5:0] op_lui   = 6'b001111;
    localparam logic [5:0] op_cop1  = 6'b010001;
    localparam logic [5:0] op_lb    = 6'b100000;
    localparam logic [5:0] op_lh    = 6'b100001;
    localparam logic [5:0] op_lw    = 6'b100011;
    localparam logic [5:0] op_lbu   = 6'b100100;
    localparam logic [5:0] op_lhu   = 6'b100101;
    localparam logic [5:0] op_sb    = 6'b101000;
    localparam logic [5:0] op_sh    = 6'b101001;
    localparam logic [5:0] op_sw    = 6'b101011;
    localparam logic [5:0] op_lwc1  = 6'b110001;
    localparam logic [5:0] op_swc1  = 6'b111001;

    // r-type function codes
    localparam logic [5:0] funct_jr   = 6'b001000;
    localparam logic [5:0] funct_jalr = 6'b001001;
    localparam logic [5:0] funct_add  = 6'b100000;
    localparam logic [5:0] funct_addu = 6'b100001;
    localparam logic [5:0] funct_sub  = 6'b100010;
    localparam logic [5:0] funct_subu = 6'b100011;
    localparam logic [5:0] funct_and  = 6'b100100;
    localparam logic [5:0] funct_or   = 6'b100101;
    localparam logic [5:0] funct_xor  = 6'b100110;
    localparam logic [5:0] funct_nor  = 6'b100111;
    localparam logic [5:0] funct_slt  = 6'b101010;
    localparam logic [5:0] funct_sltu = 6'b101011;

    // cop1 function group
    localparam logic [5:0] funct_fadd = 6'b000000;
    localparam logic [5:0] funct_fsub = 6'b000001;
    localparam logic [5:0] funct_fmul = 6'b000010;
    localparam logic [5:0] funct_fdiv = 6'b000011;

    // aluop classes carried in the control word
    localparam logic [3:0] aluop_add   = 4'b0000;
    localparam logic [3:0] aluop_sub   = 4'b0001;
    localparam logic [3:0] aluop_lez   = 4'b0010;
    localparam logic [3:0] aluop_or    = 4'b0011;
    localparam logic [3:0] aluop_lui   = 4'b0100;
    localparam logic [3:0] aluop_xor   = 4'b0101;
    localparam logic [3:0] aluop_slt   = 4'b0110;
    localparam logic [3:0] aluop_and   = 4'b0111;
    localparam logic [3:0] aluop_sltu  = 4'b1000;
    localparam logic [3:0] aluop_gtz   = 4'b1110;
    localparam logic [3:0] aluop_rtype = 4'b1111;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_nor, alu_slt, alu_sltu, alu_lui
    } alu_op_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [addr_width-1:0] rs;
        logic [addr_width-1:0] rt;
        logic [addr_width-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [addr_width-1:0] rs;
        logic [addr_width-1:0] rt;
        logic [15:0]           imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    typedef struct packed {
        logic       regwrite;
        logic       regdst;
        logic [1:0] alusrc;      // 00 rt, 01 signed imm, 11 unsigned imm
        logic       branch;
        logic [1:0] memwrite;
        logic       memtoreg;
        logic       jump;
        logic       jr;
        logic [3:0] aluop;
        logic       ne;
        logic [1:0] half;
        logic       b;
        logic       lbu;
        logic       link;
        logic       spregwrite;
        logic [3:0] fpu_control;
        logic       fpu_mem_write;
        logic       fp_regwrite;
        logic       mem_to_fp;
        logic       fp_regdst;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        alu_op_t               alu_op;
        logic [addr_width-1:0] rs;
        logic [addr_width-1:0] rt;
        logic [addr_width-1:0] dst;
        logic [data_width-1:0] imm;     // already extended
        logic                  illegal;
        instr_t                instr;
    } dec_op_t;

    typedef struct packed {
        instr_t                instr;
        logic                  wr_en;
        logic [addr_width-1:0] wr_reg;
        logic [data_width-1:0] wr_data;
        logic                  illegal;
        logic                  executed;
    } retire_t;

endpackage

// ==== decoder/alu_decoder.sv ====
`timescale 1ns/10ps

module alu_decoder (
    input  logic [3:0]        aluop,
    input  logic [5:0]        funct,
    output mips_pkg::alu_op_t alu_op
);

    always_comb begin
        case (aluop)
            mips_pkg::aluop_add:  alu_op = mips_pkg::alu_add;
            mips_pkg::aluop_sub:  alu_op = mips_pkg::alu_sub;   // beq, bne compare
            mips_pkg::aluop_lez:  alu_op = mips_pkg::alu_slt;
            mips_pkg::aluop_gtz:  alu_op = mips_pkg::alu_slt;
            mips_pkg::aluop_or:   alu_op = mips_pkg::alu_or;
            mips_pkg::aluop_lui:  alu_op = mips_pkg::alu_lui;
            mips_pkg::aluop_xor:  alu_op = mips_pkg::alu_xor;
            mips_pkg::aluop_slt:  alu_op = mips_pkg::alu_slt;
            mips_pkg::aluop_and:  alu_op = mips_pkg::alu_and;
            mips_pkg::aluop_sltu: alu_op = mips_pkg::alu_sltu;
            mips_pkg::aluop_rtype: begin
                case (funct)
                    mips_pkg::funct_add,
                    mips_pkg::funct_addu: alu_op = mips_pkg::alu_add;
                    mips_pkg::funct_sub,
                    mips_pkg::funct_subu: alu_op = mips_pkg::alu_sub;
                    mips_pkg::funct_and:  alu_op = mips_pkg::alu_and;
                    mips_pkg::funct_or:   alu_op = mips_pkg::alu_or;
                    mips_pkg::funct_xor:  alu_op = mips_pkg::alu_xor;
                    mips_pkg::funct_nor:  alu_op = mips_pkg::alu_nor;
                    mips_pkg::funct_slt:  alu_op = mips_pkg::alu_slt;
                    mips_pkg::funct_sltu: alu_op = mips_pkg::alu_sltu;
                    default:              alu_op = mips_pkg::alu_add;  // shifts, mult etc
                endcase
            end
            default: alu_op = mips_pkg::alu_add;
        endcase
    end

endmodule

// ==== decoder/main_decoder.sv ====
`timescale 1ns/10ps

module main_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  mips_pkg::instr_t  instr,
    output logic              dec_valid,
    output mips_pkg::dec_op_t dec
);

    mips_pkg::ctrl_t   ctrl;
    logic              illegal;
    mips_pkg::alu_op_t alu_op;
    mips_pkg::dec_op_t dec_next;

    // control word groups, msb first:
    // regwrite regdst alusrc | branch memwrite memtoreg | jump jr | aluop |
    // ne half b lbu | link spregwrite | fpu_control | fpu_mem_write fp_regwrite mem_to_fp fp_regdst
    always_comb begin
        ctrl    = '0;
        illegal = 1'b0;
        case (instr.r.op)
            mips_pkg::op_rtype: begin
                if (instr.r.funct == mips_pkg::funct_jr) begin
                    ctrl = 29'b0000_0000_11_0000_00000_00_0000_0000;
                end else if (instr.r.funct == mips_pkg::funct_jalr) begin
                    ctrl = 29'b1100_0000_11_0000_00000_10_0000_0000;
                end else begin
                    ctrl = 29'b1100_0000_00_1111_00000_00_0000_0000;
                end
            end
            mips_pkg::op_cop1: begin
                case (instr.r.funct)
                    mips_pkg::funct_fadd:
                        ctrl = 29'b0000_0000_00_0000_00000_00_0000_0101;
                    mips_pkg::funct_fsub:
                        ctrl = 29'b0000_0000_00_0000_00000_00_0001_0101;
                    mips_pkg::funct_fmul:
                        ctrl = 29'b0000_0000_00_0000_00000_00_0010_0101;
                    mips_pkg::funct_fdiv:
                        ctrl = 29'b0000_0000_00_0000_00000_00_0011_0101;
                    default: ctrl = '0;  // other fp functs do nothing
                endcase
            end
            mips_pkg::op_lw:    ctrl = 29'b1001_0001_00_0000_00000_00_0000_0000;
            mips_pkg::op_sw:    ctrl = 29'b0001_0010_00_0000_00000_00_0000_0000;
            mips_pkg::op_lh:    ctrl = 29'b1001_0001_00_0000_00100_00_0000_0000;
            mips_pkg::op_lb:    ctrl = 29'b1001_0001_00_0000_00110_00_0000_0000;
            mips_pkg::op_lbu:   ctrl = 29'b1001_0001_00_0000_00001_00_0000_0000;
            mips_pkg::op_lhu:   ctrl = 29'b1001_0001_00_0000_01000_00_0000_0000;
            mips_pkg::op_sh:    ctrl = 29'b0001_0100_00_0000_00000_00_0000_0000;
            mips_pkg::op_sb:    ctrl = 29'b0001_0110_00_0000_00000_00_0000_0000;
            mips_pkg::op_beq:   ctrl = 29'b0000_1000_00_0001_00000_00_0000_0000;
            mips_pkg::op_bne:   ctrl = 29'b0000_1000_00_0001_10000_00_0000_0000;
            mips_pkg::op_blez:  ctrl = 29'b0000_1000_00_0010_00000_00_0000_0000;
            mips_pkg::op_bgtz:  ctrl = 29'b0000_1000_00_1110_00000_00_0000_0000;
            mips_pkg::op_addi,
            mips_pkg::op_addiu: ctrl = 29'b1001_0000_00_0000_00000_00_0000_0000;
            mips_pkg::op_slti:  ctrl = 29'b1001_0000_00_0110_00000_00_0000_0000;
            mips_pkg::op_sltiu: ctrl = 29'b1011_0000_00_1000_00000_00_0000_0000;
            mips_pkg::op_andi:  ctrl = 29'b1011_0000_00_0111_00000_00_0000_0000;
            mips_pkg::op_ori:   ctrl = 29'b1011_0000_00_0011_00000_00_0000_0000;
            mips_pkg::op_xori:  ctrl = 29'b1011_0000_00_0101_00000_00_0000_0000;
            mips_pkg::op_lui:   ctrl = 29'b1001_0000_00_0100_00000_00_0000_0000;
            mips_pkg::op_j:     ctrl = 29'b0000_0000_10_0000_00000_00_0000_0000;
            mips_pkg::op_jal:   ctrl = 29'b1000_0000_10_0000_00000_10_0000_0000;
            mips_pkg::op_lwc1:  ctrl = 29'b0001_0000_00_0000_00000_00_0000_0110;
            mips_pkg::op_swc1:  ctrl = 29'b0001_0010_00_0000_00000_00_0000_1000;
            default:            illegal = 1'b1;  // control stays zero
        endcase
    end

    alu_decoder alu_decoder_i (
        .aluop  (ctrl.aluop),
        .funct  (instr.r.funct),
        .alu_op (alu_op)
    );

    always_comb begin
        dec_next.ctrl    = ctrl;
        dec_next.alu_op  = alu_op;
        dec_next.rs      = instr.r.rs;
        dec_next.rt      = instr.r.rt;
        dec_next.dst     = ctrl.regdst ? instr.r.rd : instr.i.rt;
        dec_next.illegal = illegal;
        dec_next.instr   = instr;
        if (ctrl.alusrc == 2'b11) begin
            dec_next.imm = {16'b0, instr.i.imm};  // andi ori xori sltiu
        end else begin
            dec_next.imm = {{16{instr.i.imm[15]}}, instr.i.imm};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec <= dec_next;
        end
    end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rd_addr_a,
    input  logic [4:0]  rd_addr_b,
    output logic [31:0] rd_data_a,
    output logic [31:0] rd_data_b,
    input  logic        wr_en,
    input  logic [4:0]  wr_reg,
    input  logic [31:0] wr_data
);

    logic [mips_pkg::data_width-1:0] regs [mips_pkg::reg_count];

    // both ports read straight from the array
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mips_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_reg != 5'd0) begin  // r0 stays zero
            regs[wr_reg] <= wr_data;
        end
    end

endmodule

// ==== hdl/alu_execute.sv ====
`timescale 1ns/10ps

module alu_execute (
    input  logic              clk,
    input  logic              reset,
    input  logic              dec_valid,
    input  mips_pkg::dec_op_t dec,
    output logic [4:0]        rs_addr,
    output logic [4:0]        rt_addr,
    input  logic [31:0]       rs_data,
    input  logic [31:0]       rt_data,
    output logic              wr_en,
    output logic [4:0]        wr_reg,
    output logic [31:0]       wr_data,
    output logic              retire_valid,
    output mips_pkg::retire_t retire
);

    logic [31:0]       op_a;
    logic [31:0]       rt_fwd;
    logic [31:0]       op_b;
    logic [31:0]       result;
    logic              funct_ok;
    logic              executed;
    mips_pkg::retire_t retire_next;

    assign rs_addr = dec.rs;
    assign rt_addr = dec.rt;

    // write still pending in the register file
    assign op_a   = (wr_en && wr_reg == dec.rs) ? wr_data : rs_data;
    assign rt_fwd = (wr_en && wr_reg == dec.rt) ? wr_data : rt_data;
    assign op_b   = (dec.ctrl.alusrc == 2'b00) ? rt_fwd : dec.imm;

    always_comb begin
        case (dec.alu_op)
            mips_pkg::alu_add:  result = op_a + op_b;
            mips_pkg::alu_sub:  result = op_a - op_b;
            mips_pkg::alu_and:  result = op_a & op_b;
            mips_pkg::alu_or:   result = op_a | op_b;
            mips_pkg::alu_xor:  result = op_a ^ op_b;
            mips_pkg::alu_nor:  result = ~(op_a | op_b);
            mips_pkg::alu_slt:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            mips_pkg::alu_sltu: result = {31'b0, op_a < op_b};
            mips_pkg::alu_lui:  result = {op_b[15:0], 16'b0};
            default:            result = '0;
        endcase
    end

    // r-type functs that the alu really implements
    always_comb begin
        funct_ok = 1'b1;
        if (dec.ctrl.aluop == mips_pkg::aluop_rtype) begin
            case (dec.instr.r.funct)
                mips_pkg::funct_add, mips_pkg::funct_addu,
                mips_pkg::funct_sub, mips_pkg::funct_subu,
                mips_pkg::funct_and, mips_pkg::funct_or,
                mips_pkg::funct_xor, mips_pkg::funct_nor,
                mips_pkg::funct_slt, mips_pkg::funct_sltu: funct_ok = 1'b1;
                default:                                   funct_ok = 1'b0;
            endcase
        end
    end

    // loads and jumps/links also set regwrite
    assign executed = dec.ctrl.regwrite && !dec.ctrl.memtoreg && !dec.ctrl.jump
                      && !dec.illegal && funct_ok && dec.dst != 5'd0;

    always_comb begin
        retire_next.instr    = dec.instr;
        retire_next.wr_en    = executed;
        retire_next.wr_reg   = dec.dst;
        retire_next.wr_data  = result;
        retire_next.illegal  = dec.illegal;
        retire_next.executed = executed;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
            wr_en        <= 1'b0;
        end else begin
            retire_valid <= dec_valid;
            wr_en        <= dec_valid && executed;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            retire <= retire_next;
        end
    end

    assign wr_reg  = retire.wr_reg;   // committed one edge after retire
    assign wr_data = retire.wr_data;

endmodule

// ==== hdl/mips_int_core.sv ====
`timescale 1ns/10ps

module mips_int_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  mips_pkg::instr_t  instr,
    output logic              retire_valid,
    output mips_pkg::retire_t retire
);

    logic              dec_valid;
    mips_pkg::dec_op_t dec;
    logic [4:0]        rs_addr;
    logic [4:0]        rt_addr;
    logic [31:0]       rs_data;
    logic [31:0]       rt_data;
    logic              wr_en;
    logic [4:0]        wr_reg;
    logic [31:0]       wr_data;

    main_decoder main_decoder_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    register_file register_file_i (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (rs_addr),
        .rd_addr_b (rt_addr),
        .rd_data_a (rs_data),
        .rd_data_b (rt_data),
        .wr_en     (wr_en),
        .wr_reg    (wr_reg),
        .wr_data   (wr_data)
    );

    alu_execute alu_execute_i (
        .clk          (clk),
        .reset        (reset),
        .dec_valid    (dec_valid),
        .dec          (dec),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .wr_en        (wr_en),
        .wr_reg       (wr_reg),
        .wr_data      (wr_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// ==== testbench/mips_ref_model.svh ====
// architectural registers as the model sees them, r0 is never written
logic [31:0] arch_regs [mips_pkg::reg_count];

task automatic clear_model();
    for (int i = 0; i < mips_pkg::reg_count; i++) begin
        arch_regs[i] = '0;
    end
endtask

function automatic bit is_known_op(input logic [5:0] op);
    case (op)
        mips_pkg::op_rtype, mips_pkg::op_j, mips_pkg::op_jal, mips_pkg::op_beq,
        mips_pkg::op_bne, mips_pkg::op_blez, mips_pkg::op_bgtz, mips_pkg::op_addi,
        mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu, mips_pkg::op_andi,
        mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui, mips_pkg::op_cop1,
        mips_pkg::op_lb, mips_pkg::op_lh, mips_pkg::op_lw, mips_pkg::op_lbu,
        mips_pkg::op_lhu, mips_pkg::op_sb, mips_pkg::op_sh, mips_pkg::op_sw,
        mips_pkg::op_lwc1, mips_pkg::op_swc1: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// op rs rt rd shamt funct
function automatic mips_pkg::instr_t encode_r(input logic [5:0] funct, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd);
    return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, funct};
endfunction

function automatic mips_pkg::instr_t encode_i(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// expected retire report, updates the model state in program order
function automatic mips_pkg::retire_t predict_retire(input mips_pkg::instr_t w);
    mips_pkg::retire_t pred;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       sx;
    logic [31:0]       zx;
    logic [31:0]       res;
    logic              writes;
    logic [4:0]        dst;
    a      = arch_regs[w.r.rs];
    b      = arch_regs[w.r.rt];
    sx     = {{16{w.i.imm[15]}}, w.i.imm};
    zx     = {16'd0, w.i.imm};
    res    = '0;
    writes = 1'b1;
    dst    = w.i.rt;
    case (w.r.op)
        mips_pkg::op_rtype: begin
            dst = w.r.rd;
            case (w.r.funct)
                mips_pkg::funct_add, mips_pkg::funct_addu: res = a + b;
                mips_pkg::funct_sub, mips_pkg::funct_subu: res = a - b;
                mips_pkg::funct_and:  res = a & b;
                mips_pkg::funct_or:   res = a | b;
                mips_pkg::funct_xor:  res = a ^ b;
                mips_pkg::funct_nor:  res = ~(a | b);
                mips_pkg::funct_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                mips_pkg::funct_sltu: res = (a < b) ? 32'd1 : 32'd0;
                default:              writes = 1'b0;  // jr, jalr, shifts
            endcase
        end
        mips_pkg::op_addi, mips_pkg::op_addiu: res = a + sx;
        mips_pkg::op_slti:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
        mips_pkg::op_sltiu: res = (a < zx) ? 32'd1 : 32'd0;  // zero-extended here
        mips_pkg::op_andi:  res = a & zx;
        mips_pkg::op_ori:   res = a | zx;
        mips_pkg::op_xori:  res = a ^ zx;
        mips_pkg::op_lui:   res = {w.i.imm, 16'd0};
        default:            writes = 1'b0;
    endcase
    if (dst == 5'd0) begin
        writes = 1'b0;
    end
    if (writes) begin
        arch_regs[dst] = res;
    end
    pred.instr    = w;
    pred.wr_en    = writes;
    pred.wr_reg   = dst;
    pred.wr_data  = res;
    pred.illegal  = !is_known_op(w.r.op);
    pred.executed = writes;
    return pred;
endfunction

// ==== testbench/tb_mips_int_core.sv ====
`timescale 1ns/10ps

module tb_mips_int_core;

    localparam int reset_cycles = 5;
    localparam int max_gap      = 2;
    localparam int n_alu        = 400;
    localparam int n_dep        = 160;
    localparam int n_zero       = 30;
    localparam int n_misc       = 120;
    // every slot at its longest gap, plus lead-in, drain and margin
    localparam int cycle_limit  = reset_cycles + 4 + 2 * (mips_pkg::reg_count + 1)
                                  + (n_alu + n_misc) * (max_gap + 1) + n_dep + 2 * n_zero
                                  + 8 + 20;

    localparam logic [5:0] alu_functs [10] = '{
        mips_pkg::funct_add, mips_pkg::funct_addu, mips_pkg::funct_sub, mips_pkg::funct_subu,
        mips_pkg::funct_and, mips_pkg::funct_or, mips_pkg::funct_xor, mips_pkg::funct_nor,
        mips_pkg::funct_slt, mips_pkg::funct_sltu};
    localparam logic [5:0] imm_ops [8] = '{
        mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu,
        mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui};
    localparam logic [5:0] no_write_ops [17] = '{  // known but never write a register
        mips_pkg::op_lb, mips_pkg::op_lh, mips_pkg::op_lw, mips_pkg::op_lbu, mips_pkg::op_lhu,
        mips_pkg::op_sb, mips_pkg::op_sh, mips_pkg::op_sw, mips_pkg::op_beq, mips_pkg::op_bne,
        mips_pkg::op_blez, mips_pkg::op_bgtz, mips_pkg::op_j, mips_pkg::op_jal,
        mips_pkg::op_cop1, mips_pkg::op_lwc1, mips_pkg::op_swc1};

    typedef struct packed {
        mips_pkg::retire_t ret;
        logic [31:0]       due;      // cycle of the expected retire_valid
        logic [2:0]        test_id;
    } pending_t;

    logic              clk;
    logic              reset;
    logic              instr_valid;
    mips_pkg::instr_t  instr;
    logic              retire_valid;
    mips_pkg::retire_t retire;
    logic [31:0]       cycle;
    int                errors;
    int                checks;
    logic [4:0]        reg_pool [4];
    pending_t          pending_q [$];

    `include "mips_ref_model.svh"

    mips_int_core mips_int_core_i (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "reset_state";
            3'd2:    return "alu_ops";
            3'd3:    return "back_to_back";
            3'd4:    return "reg_zero";
            3'd5:    return "no_write";
            default: return "readback";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s expected %h actual %h at cycle %0d", name, expected, actual, cycle);
        end
    endtask

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $urandom();
        return r[4:0];
    endfunction

    function automatic logic [4:0] pool_reg();
        logic [31:0] r;
        r = $urandom();
        return reg_pool[r[1:0]];
    endfunction

    function automatic int rand_gap();
        return $urandom_range(max_gap, 0);
    endfunction

    function automatic logic [15:0] rand_imm();
        logic [31:0] r;
        r = $urandom();
        case (r[19:16])  // sign boundaries a quarter of the time
            4'd0:    return 16'h8000;
            4'd1:    return 16'hffff;
            4'd2:    return 16'h7fff;
            4'd3:    return 16'h0000;
            default: return r[15:0];
        endcase
    endfunction

    function automatic mips_pkg::instr_t gen_alu(input logic [4:0] rs, input logic [4:0] rt,
                                                 input logic [4:0] dst);
        logic [31:0] pick;
        logic [31:0] idx;
        pick = $urandom_range(17, 0);
        if (pick < 32'd10) begin
            return encode_r(alu_functs[pick[3:0]], rs, rt, dst);
        end
        idx = pick - 32'd10;
        return encode_i(imm_ops[idx[2:0]], rs, dst, rand_imm());
    endfunction

    function automatic mips_pkg::instr_t gen_no_write();
        logic [31:0] r;
        logic [31:0] sel;
        logic [31:0] pick;
        logic [5:0]  op;
        logic [5:0]  funct;
        r    = $urandom();
        sel  = $urandom_range(3, 0);
        pick = $urandom_range(16, 0);
        if (sel < 32'd2) begin
            return {no_write_ops[pick[4:0]], r[25:0]};
        end else if (sel == 32'd2) begin
            op = r[31:26];
            while (is_known_op(op)) begin  // 38 free opcodes, ends quickly
                r  = $urandom();
                op = r[31:26];
            end
            return {op, r[25:0]};
        end
        funct = r[5:0];
        for (int k = 0; k < 10; k++) begin
            if (alu_functs[k] == funct) begin
                funct = r[6] ? mips_pkg::funct_jr : mips_pkg::funct_jalr;
            end
        end
        return {mips_pkg::op_rtype, r[25:6], funct};
    endfunction

    task automatic issue(input mips_pkg::instr_t w, input logic [2:0] test_id);
        pending_t e;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        e.ret     = predict_retire(w);
        e.due     = cycle + 32'd3;  // cycle lags this edge by one, retire comes two edges on
        e.test_id = test_id;
        pending_q.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    // addu rX, rX, r0 for every register
    task automatic read_back(input logic [2:0] test_id);
        for (int r = 0; r < mips_pkg::reg_count; r++) begin
            issue(encode_r(mips_pkg::funct_addu, 5'(r), 5'd0, 5'(r)), test_id);
        end
        idle(1);
    endtask

    always @(negedge clk) begin
        pending_t e;
        string    t;
        if (retire_valid === 1'b1) begin
            if (pending_q.size() == 0) begin
                errors++;
                $display("Error: retire_valid at cycle %0d with no instruction outstanding",
                         cycle);
            end else begin
                e = pending_q.pop_front();
                t = test_name(e.test_id);
                check_value({t, " retire cycle"}, e.due, cycle);
                check_value({t, " instr"}, e.ret.instr, retire.instr);
                check_value({t, " wr_en"}, 32'(e.ret.wr_en), 32'(retire.wr_en));
                check_value({t, " executed"}, 32'(e.ret.executed), 32'(retire.executed));
                check_value({t, " illegal"}, 32'(e.ret.illegal), 32'(retire.illegal));
                if (e.ret.wr_en) begin
                    check_value({t, " wr_reg"}, 32'(e.ret.wr_reg), 32'(retire.wr_reg));
                    check_value({t, " wr_data"}, e.ret.wr_data, retire.wr_data);
                end
            end
        end else if (retire_valid !== 1'b0) begin
            errors++;
            $display("Error: retire_valid is unknown at cycle %0d", cycle);
        end else if (pending_q.size() != 0 && pending_q[0].due <= cycle) begin
            errors++;
            $display("Error: no retire_valid for %s instruction %h due at cycle %0d",
                     test_name(pending_q[0].test_id), pending_q[0].ret.instr, pending_q[0].due);
            pending_q.delete(0);
        end
    end

    initial begin
        wait (cycle >= 32'(cycle_limit));
        errors++;
        $display("Error: timeout at cycle %0d with %0d retires outstanding",
                 cycle, pending_q.size());
        $display("checks %0d, errors %0d", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(32'h47e2_1ffb));
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        cycle       = '0;
        errors      = 0;
        checks      = 0;
        clear_model();
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        idle(4);  // nothing may retire before the first strobe

        read_back(3'd1);

        repeat (n_alu) begin
            issue(gen_alu(rand_reg(), rand_reg(), rand_reg()), 3'd2);
            idle(rand_gap());
        end

        // small register pool so consecutive instructions collide
        for (int i = 0; i < n_dep; i++) begin
            if (i % 40 == 0) begin
                for (int p = 0; p < 4; p++) begin
                    reg_pool[p] = rand_reg();
                end
            end
            issue(gen_alu(pool_reg(), pool_reg(), pool_reg()), 3'd3);
        end
        idle(1);

        repeat (n_zero) begin
            issue(gen_alu(rand_reg(), rand_reg(), 5'd0), 3'd4);
            issue(encode_r(mips_pkg::funct_or, 5'd0, 5'd0, rand_reg() | 5'd1), 3'd4);
        end
        idle(1);

        repeat (n_misc) begin
            issue(gen_no_write(), 3'd5);
            idle(rand_gap());
        end
        read_back(3'd6);

        while (pending_q.size() != 0) @(posedge clk);
        idle(4);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && checks != 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== mips_int_core.f ====
+incdir+testbench
common/mips_pkg.sv
decoder/alu_decoder.sv
decoder/main_decoder.sv
hdl/register_file.sv
hdl/alu_execute.sv
hdl/mips_int_core.sv
testbench/tb_mips_int_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, and judge the run by its output
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mips_int_core.f --top-module tb_mips_int_core -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
